// File: noc_pkg.sv
// shared types for the wormhole output port
// a flit is a 2-bit kind plus a fixed-width payload
// single flits open and close a packet on their own
package noc_pkg;

  // payload bits carried by every flit
  parameter int PAYLOAD_WIDTH = 32;

  // flit opcode, decides packet framing
  typedef enum logic [1:0] {
    FLIT_HEAD   = 2'b00,
    FLIT_BODY   = 2'b01,
    FLIT_TAIL   = 2'b10,
    // head and tail in one flit
    FLIT_SINGLE = 2'b11
  } flit_kind_e;

  // output lock of the wormhole controller
  typedef enum logic {
    LOCK_IDLE = 1'b0,
    LOCK_BUSY = 1'b1
  } lock_state_e;

  // one flit as it sits in a buffer or on the output
  typedef struct packed {
    flit_kind_e                 kind;
    logic [PAYLOAD_WIDTH-1:0]   payload;
  } flit_t;

endpackage

// File: rr_arbiter.sv
// round-robin arbiter with one-hot and index grant
// grant is combinational from req, the pointer moves one edge after a pulse
// grant pulse keeps the winner first, update pulse moves past it
// works for any NUM_PORTS of 1 or more
module rr_arbiter #(
  parameter int NUM_PORTS = 4,
  localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic [NUM_PORTS-1:0] req_i,
  input  logic                 grant_pulse_i,
  input  logic                 update_pulse_i,
  output logic [NUM_PORTS-1:0] grant_o,
  output logic [IDX_W-1:0]     grant_id_o
);
  localparam logic [IDX_W-1:0] LAST_ID = IDX_W'(NUM_PORTS - 1);

  // pointer names the port that currently has top priority
  logic [IDX_W-1:0]                ptr_q;
  logic [IDX_W-1:0]                ptr_d;
  logic [2*NUM_PORTS-1:0]          req_dbl;
  logic [2*NUM_PORTS-1:0]          sel_dbl;
  logic [NUM_PORTS-1:0]            req_rot;
  logic [NUM_PORTS-1:0]            sel_rot;
  logic [IDX_W-1:0][NUM_PORTS-1:0] id_mask;

  // rotate right so the pointer port sits on bit 0
  assign req_dbl = {req_i, req_i} >> ptr_q;
  assign req_rot = req_dbl[NUM_PORTS-1:0];

  // lowest set bit wins, x & -x
  assign sel_rot = req_rot & (~req_rot + 1'b1);

  // undo the rotation, the upper half holds the result
  assign sel_dbl = {sel_rot, sel_rot} << ptr_q;
  assign grant_o = sel_dbl[2*NUM_PORTS-1:NUM_PORTS];

  // index from one-hot
  // mask bit b of port p is bit b of p
  for (genvar b = 0; b < IDX_W; b++) begin : gen_id_bit
    for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_id_mask
      assign id_mask[b][p] = ((p >> b) % 2) == 1;
    end
    assign grant_id_o[b] = |(grant_o & id_mask[b]);
  end

  // update wins over grant, both never come together
  always_comb begin
    ptr_d = ptr_q;
    if (update_pulse_i) begin
      // next search starts one past the finished winner
      ptr_d = (grant_id_o == LAST_ID) ? '0 : grant_id_o + 1'b1;
    end else if (grant_pulse_i) begin
      ptr_d = grant_id_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else begin
      ptr_q <= ptr_d;
    end
  end

  // at most one winner and only among the requesters
  a_grant_legal: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(grant_o) && ((grant_o & ~req_i) == '0));

  // pulses come one at a time and only with a live request
  a_pulse_legal: assert property (@(posedge clk_i) disable iff (reset_i)
    (grant_pulse_i || update_pulse_i) |-> (|req_i) && !(grant_pulse_i && update_pulse_i));

endmodule

// File: flit_fifo.sv
// per-port flit buffer, circular with an occupancy count
// head_flit_o is meaningful only while empty_o is low
// senders must watch full_o, the reader must watch empty_o
// any FIFO_DEPTH of 1 or more, powers of two expected
module flit_fifo #(
  parameter int FIFO_DEPTH = 4,
  localparam int ADDR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1,
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1)
) (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           push_i,
  input  noc_pkg::flit_t push_flit_i,
  input  logic           pop_i,
  output noc_pkg::flit_t head_flit_o,
  output logic           empty_o,
  output logic           full_o
);
  localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0]  DEPTH_CNT = CNT_W'(FIFO_DEPTH);

  noc_pkg::flit_t    mem_q [FIFO_DEPTH];
  logic [ADDR_W-1:0] wr_ptr_q;
  logic [ADDR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              do_push;
  logic              do_pop;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == DEPTH_CNT);

  // illegal strobes are dropped here and flagged below
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // oldest entry straight from storage
  assign head_flit_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_ADDR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_ADDR) ? '0 : rd_ptr_q + 1'b1;
      end
      // push with pop leaves the count alone
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // storage array
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_flit_i;
    end
  end

  // sender keeps off a full buffer
  a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
    push_i |-> !full_o);

  // controller only pops a port it saw non-empty
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> !empty_o);

endmodule

// File: wormhole_ctrl.sv
// wormhole lock for one output port
// locks to a port on a popped head, releases on a popped tail or single
// pops only when not stalled and the arbiter has a winner
// the only block that looks at the downstream stall
module wormhole_ctrl #(
  parameter int NUM_PORTS = 4,
  localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic [NUM_PORTS-1:0] empty_i,
  input  noc_pkg::flit_kind_e  head_kind_i [NUM_PORTS],
  input  logic                 out_stall_i,
  input  logic [NUM_PORTS-1:0] grant_i,
  input  logic [IDX_W-1:0]     grant_id_i,
  output logic [NUM_PORTS-1:0] req_o,
  output logic [NUM_PORTS-1:0] pop_o,
  output logic                 take_o,
  output logic                 hold_o,
  output logic                 grant_pulse_o,
  output logic                 update_pulse_o
);
  noc_pkg::lock_state_e state_q;
  noc_pkg::lock_state_e state_d;
  logic [IDX_W-1:0]     lock_id_q;
  logic [IDX_W-1:0]     lock_id_d;
  logic [NUM_PORTS-1:0] lock_mask;
  noc_pkg::flit_kind_e  pop_kind;
  logic                 pop_is_head;
  logic                 pop_is_last;

  // one-hot of the locked port
  assign lock_mask = NUM_PORTS'(1) << lock_id_q;

  // idle: every non-empty port competes
  // busy: only the locked port, and only once it has data again
  assign req_o = (state_q == noc_pkg::LOCK_BUSY) ? (~empty_i & lock_mask) : ~empty_i;

  // stall goes to the output stage as its hold
  assign hold_o = out_stall_i;
  assign take_o = !out_stall_i && (|grant_i);
  assign pop_o  = take_o ? grant_i : '0;

  // kind of the flit leaving this cycle
  assign pop_kind    = head_kind_i[grant_id_i];
  assign pop_is_head = (pop_kind == noc_pkg::FLIT_HEAD);
  assign pop_is_last = (pop_kind == noc_pkg::FLIT_TAIL) || (pop_kind == noc_pkg::FLIT_SINGLE);

  // head keeps the winner first, tail or single rotates past it
  assign grant_pulse_o  = take_o && pop_is_head;
  assign update_pulse_o = take_o && pop_is_last;

  // lock moves on the same edge as the pop
  always_comb begin
    state_d   = state_q;
    lock_id_d = lock_id_q;
    if (take_o) begin
      if (pop_is_head) begin
        state_d   = noc_pkg::LOCK_BUSY;
        lock_id_d = grant_id_i;
      end else if (pop_is_last) begin
        state_d = noc_pkg::LOCK_IDLE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= noc_pkg::LOCK_IDLE;
      lock_id_q <= '0;
    end else begin
      state_q   <= state_d;
      lock_id_q <= lock_id_d;
    end
  end

  // a packet can only start from idle
  a_idle_opens: assert property (@(posedge clk_i) disable iff (reset_i)
    (take_o && state_q == noc_pkg::LOCK_IDLE) |->
      (pop_is_head || pop_kind == noc_pkg::FLIT_SINGLE));

  // while locked, only the rest of the same packet leaves
  a_busy_continues: assert property (@(posedge clk_i) disable iff (reset_i)
    (take_o && state_q == noc_pkg::LOCK_BUSY) |->
      (pop_kind == noc_pkg::FLIT_BODY || pop_kind == noc_pkg::FLIT_TAIL) &&
      (grant_id_i == lock_id_q));

endmodule

// File: flit_out_stage.sv
// registered output of the port
// loads the granted buffer head and its index when take is high
// hold freezes valid, flit and source together
module flit_out_stage #(
  parameter int NUM_PORTS = 4,
  localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           take_i,
  input  logic           hold_i,
  input  logic [IDX_W-1:0] grant_id_i,
  input  noc_pkg::flit_t head_flit_i [NUM_PORTS],
  output logic           out_valid_o,
  output noc_pkg::flit_t out_flit_o,
  output logic [IDX_W-1:0] out_src_o
);
  noc_pkg::flit_t sel_flit;

  // head of the winning buffer
  assign sel_flit = head_flit_i[grant_id_i];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_valid_o <= 1'b0;
    end else if (!hold_i) begin
      out_valid_o <= take_i;
    end
  end

  // data keeps its last value when nothing is taken
  always_ff @(posedge clk_i) begin
    if (take_i && !hold_i) begin
      out_flit_o <= sel_flit;
      out_src_o  <= grant_id_i;
    end
  end

endmodule

// File: noc_out_port.sv
// one output port of a wormhole router
// per-port buffers, round-robin arbiter, packet lock, output register
// earliest path is push at edge t, valid after edge t+1
// no routing, no virtual channels, no credits
module noc_out_port #(
  parameter int NUM_PORTS = 4,
  parameter int FIFO_DEPTH = 4,
  localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic [NUM_PORTS-1:0] push_i,
  input  noc_pkg::flit_t       push_flit_i [NUM_PORTS],
  output logic [NUM_PORTS-1:0] full_o,
  input  logic                 out_stall_i,
  output logic                 out_valid_o,
  output noc_pkg::flit_t       out_flit_o,
  output logic [IDX_W-1:0]     out_src_o
);
  logic [NUM_PORTS-1:0] empty;
  logic [NUM_PORTS-1:0] req;
  logic [NUM_PORTS-1:0] grant;
  logic [NUM_PORTS-1:0] pop;
  logic [IDX_W-1:0]     grant_id;
  noc_pkg::flit_t       head_flit [NUM_PORTS];
  noc_pkg::flit_kind_e  head_kind [NUM_PORTS];
  logic                 take;
  logic                 hold;
  logic                 grant_pulse;
  logic                 update_pulse;

  // one buffer per input port
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
    flit_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo (
      .clk_i, .reset_i,
      .push_i(push_i[p]), .push_flit_i(push_flit_i[p]), .pop_i(pop[p]),
      .head_flit_o(head_flit[p]), .empty_o(empty[p]), .full_o(full_o[p])
    );
    // controller only needs the kind field
    assign head_kind[p] = head_flit[p].kind;
  end

  rr_arbiter #(.NUM_PORTS(NUM_PORTS)) i_arbiter (
    .clk_i, .reset_i, .req_i(req), .grant_pulse_i(grant_pulse),
    .update_pulse_i(update_pulse), .grant_o(grant), .grant_id_o(grant_id)
  );

  wormhole_ctrl #(.NUM_PORTS(NUM_PORTS)) i_ctrl (
    .clk_i, .reset_i, .empty_i(empty), .head_kind_i(head_kind), .out_stall_i,
    .grant_i(grant), .grant_id_i(grant_id), .req_o(req), .pop_o(pop), .take_o(take),
    .hold_o(hold), .grant_pulse_o(grant_pulse), .update_pulse_o(update_pulse)
  );

  flit_out_stage #(.NUM_PORTS(NUM_PORTS)) i_out_stage (
    .clk_i, .reset_i, .take_i(take), .hold_i(hold), .grant_id_i(grant_id),
    .head_flit_i(head_flit), .out_valid_o, .out_flit_o, .out_src_o
  );

endmodule

// File: tb_noc_out_port.sv
// testbench for noc_out_port with 4 ports and 4-deep buffers
// random packets, stall bursts, then a drained round-robin phase
// scoreboard records a push at the edge that accepts it
module tb_noc_out_port;
  localparam int NP = 4;
  localparam int DEPTH = 4;
  localparam int PW = noc_pkg::PAYLOAD_WIDTH;

  logic clk_i = 1'b0;
  logic reset_i = 1'b1;
  logic [NP-1:0] push = '0;
  noc_pkg::flit_t push_flit [NP];
  logic [NP-1:0] full;
  logic out_stall = 1'b0;
  logic out_valid;
  noc_pkg::flit_t out_flit;
  logic [1:0] out_src;

  noc_pkg::flit_t sb_q [NP][$];
  noc_pkg::flit_t exp_flit;
  logic exp_ok = 1'b0;
  logic [NP-1:0] buf_full = '0;
  logic stall_q = 1'b0;
  logic in_pkt = 1'b0;
  logic [1:0] pkt_src = '0;
  logic rr_phase = 1'b0;
  logic have_last = 1'b0;
  logic [1:0] last_src = '0;
  int errors = 0;
  int timeouts = 0;
  int rem [NP];
  int len [NP];
  int seq [NP];
  logic fresh;

  noc_out_port #(.NUM_PORTS(NP), .FIFO_DEPTH(DEPTH)) i_dut (
    .clk_i, .reset_i, .push_i(push), .push_flit_i(push_flit), .full_o(full),
    .out_stall_i(out_stall), .out_valid_o(out_valid), .out_flit_o(out_flit),
    .out_src_o(out_src)
  );

  always #4 clk_i = ~clk_i;

  // a new flit sits on the output once per unstalled load
  assign fresh = out_valid && !stall_q;

  always @(posedge clk_i) begin
    if (reset_i) begin
      for (int p = 0; p < NP; p++) sb_q[p].delete();
      in_pkt = 1'b0;
      stall_q = 1'b0;
    end else begin
      if (fresh) begin
        if (sb_q[out_src].size() > 0) void'(sb_q[out_src].pop_front());
        if (out_flit.kind == noc_pkg::FLIT_HEAD) begin
          in_pkt = 1'b1;
          pkt_src = out_src;
        end else if (out_flit.kind != noc_pkg::FLIT_BODY) begin
          in_pkt = 1'b0;
        end
        if (rr_phase) begin
          last_src = out_src;
          have_last = 1'b1;
        end
      end
      for (int p = 0; p < NP; p++) begin
        if (push[p]) sb_q[p].push_back(push_flit[p]);
      end
      stall_q = out_stall;
    end
  end

  // expected values settle between edges, the assertions sample them at the next edge
  always @(negedge clk_i) begin
    exp_ok = 1'b0;
    if (!$isunknown(out_src) && sb_q[out_src].size() > 0) begin
      exp_ok = 1'b1;
      exp_flit = sb_q[out_src][0];
    end
    // with the stall seen at the last edge the queues match the buffers
    for (int p = 0; p < NP; p++) buf_full[p] = stall_q && (sb_q[p].size() == DEPTH);
  end

  a_reset: assert property (@(posedge clk_i) reset_i |=> !out_valid && full == '0)
    else begin
      errors++;
      $display("Fail reset expected valid 0 full 0 actual valid %b full %b",
               $sampled(out_valid), $sampled(full));
    end

  a_order: assert property (@(posedge clk_i) disable iff (reset_i)
    fresh |-> exp_ok && out_flit == exp_flit)
    else begin
      errors++;
      $display("Fail order expected %h actual %h", $sampled(exp_flit), $sampled(out_flit));
    end

  a_src_tag: assert property (@(posedge clk_i) disable iff (reset_i)
    fresh |-> out_flit.payload[PW-1 -: 8] == 8'(out_src))
    else begin
      errors++;
      $display("Fail src_tag expected %h actual %h", $sampled(out_src),
               $sampled(out_flit.payload[PW-1 -: 8]));
    end

  a_framing: assert property (@(posedge clk_i) disable iff (reset_i)
    fresh |-> (in_pkt ? (out_src == pkt_src && (out_flit.kind == noc_pkg::FLIT_BODY ||
      out_flit.kind == noc_pkg::FLIT_TAIL)) : (out_flit.kind == noc_pkg::FLIT_HEAD ||
      out_flit.kind == noc_pkg::FLIT_SINGLE)))
    else begin
      errors++;
      $display("Fail framing expected src %0d in_pkt %b actual src %0d kind %0d",
               $sampled(pkt_src), $sampled(in_pkt), $sampled(out_src),
               $sampled(out_flit.kind));
    end

  a_round_robin: assert property (@(posedge clk_i) disable iff (reset_i)
    (rr_phase && have_last && fresh) |-> out_src == 2'(last_src + 1))
    else begin
      errors++;
      $display("Fail round_robin expected %0d actual %0d", 2'($sampled(last_src) + 1),
               $sampled(out_src));
    end

  a_stall_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    $past(out_stall) |-> out_valid === $past(out_valid) && out_flit === $past(out_flit) &&
      out_src === $past(out_src))
    else begin
      errors++;
      $display("Fail stall_hold expected %h actual %h", $past(out_flit), $sampled(out_flit));
    end

  for (genvar p = 0; p < NP; p++) begin : gen_full_chk
    a_full: assert property (@(posedge clk_i) disable iff (reset_i) buf_full[p] |-> full[p])
      else begin
        errors++;
        $display("Fail full_port%0d expected 1 actual %b", p, $sampled(full[p]));
      end
  end

  // one clock step, inputs change just after the edge
  task automatic step();
    @(posedge clk_i);
    #1;
    push = '0;
  endtask

  function automatic noc_pkg::flit_kind_e kind_for(input int n, input int left);
    if (n == 1) return noc_pkg::FLIT_SINGLE;
    if (left == n) return noc_pkg::FLIT_HEAD;
    if (left == 1) return noc_pkg::FLIT_TAIL;
    return noc_pkg::FLIT_BODY;
  endfunction

  // next flit of port p, a new packet of 1 to n_max flits when none is open
  task automatic send_flit(input int p, input int n_max);
    if (rem[p] == 0) begin
      len[p] = 1 + ($urandom % n_max);
      rem[p] = len[p];
    end
    push_flit[p].kind = kind_for(len[p], rem[p]);
    push_flit[p].payload = {8'(p), 24'(seq[p])};
    seq[p]++;
    rem[p]--;
    push[p] = 1'b1;
  endtask

  // closing only finishes packets already started
  task automatic random_cycle(input bit closing);
    for (int p = 0; p < NP; p++) begin
      if (!full[p] && ($urandom % 2 == 1) && (!closing || rem[p] > 0)) send_flit(p, 4);
    end
  endtask

  task automatic wait_drained(input int limit);
    int n;
    bit idle;
    n = 0;
    idle = 1'b0;
    while (!idle && n < limit) begin
      step();
      idle = 1'b1;
      for (int p = 0; p < NP; p++) if (sb_q[p].size() != 0) idle = 1'b0;
      n++;
    end
    if (!idle) begin
      timeouts++;
      $display("timeout: the buffers did not drain to the output");
    end
  endtask

  initial begin
    int n;
    int stall_left;
    void'($urandom(32'h2748dde6));
    for (int p = 0; p < NP; p++) begin
      push_flit[p] = '0;
      rem[p] = 0;
      len[p] = 1;
      seq[p] = 0;
    end
    stall_left = 0;
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    // random traffic with stall bursts
    for (int c = 0; c < 600; c++) begin
      step();
      if (stall_left > 0) stall_left--;
      else if ($urandom % 8 == 0) stall_left = 1 + ($urandom % 6);
      out_stall = (stall_left > 0);
      random_cycle(1'b0);
    end
    // finish open packets within a bound
    n = 0;
    while ((rem[0] + rem[1] + rem[2] + rem[3]) > 0 && n < 200) begin
      step();
      out_stall = 1'b0;
      random_cycle(1'b1);
      n++;
    end
    if ((rem[0] + rem[1] + rem[2] + rem[3]) > 0) begin
      timeouts++;
      $display("timeout: open packets were never completed");
    end
    out_stall = 1'b0;
    wait_drained(200);
    // fill every buffer under stall until full
    out_stall = 1'b1;
    for (int k = 0; k < DEPTH; k++) begin
      step();
      for (int p = 0; p < NP; p++) send_flit(p, 1);
    end
    repeat (3) step();
    // release into a saturated round-robin phase
    have_last = 1'b0;
    rr_phase = 1'b1;
    out_stall = 1'b0;
    for (int c = 0; c < 80; c++) begin
      step();
      for (int p = 0; p < NP; p++) if (!full[p]) send_flit(p, 1);
    end
    rr_phase = 1'b0;
    wait_drained(100);
    repeat (3) step();
    $display("errors: %0d check failures, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end
endmodule

// File: files.f
noc_pkg.sv
rr_arbiter.sv
flit_fifo.sv
wormhole_ctrl.sv
flit_out_stage.sv
noc_out_port.sv
tb_noc_out_port.sv

// File: Bender.yml
package:
  name: noc_out_port

sources:
  - noc_pkg.sv
  - rr_arbiter.sv
  - flit_fifo.sv
  - wormhole_ctrl.sv
  - flit_out_stage.sv
  - noc_out_port.sv
  - target: test
    files:
      - tb_noc_out_port.sv
